/* hdl/fb_macros.svh */
// geometry and timing constants for the RGBW panel framebuffer
// include wherever the panel dimensions or display timing are needed

`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// two stacked subpanels
`define FB_SUBPANEL_BITS 1

// red, green, blue, white
`define FB_CHANNEL_BITS 2

// 8 rows per subpanel, 32 columns
`define FB_ROW_BITS 3
`define FB_COL_BITS 5

// bits per channel, also the number of bitplanes
`define FB_DATA_BITS 8

// display cycles for bitplane 0, doubled per plane
`define FB_OE_UNIT 4

// one lane per subpanel and channel
`define FB_LANES (1 << (`FB_SUBPANEL_BITS + `FB_CHANNEL_BITS))

`endif

/* hdl/fbPkg.sv */
// shared types for the framebuffer, Wishbone slave and scanner
// import inside a module body after referencing types in the port list

`include "fb_macros.svh"

package fbPkg;

    // host pixel address: subpanel, row, column, channel from msb down
    typedef logic [`FB_SUBPANEL_BITS + `FB_ROW_BITS + `FB_COL_BITS
                   + `FB_CHANNEL_BITS - 1:0] pixelAddr_t;

    // address inside one lane, row then column
    typedef logic [`FB_ROW_BITS + `FB_COL_BITS - 1:0] bodyAddr_t;

    // subpanel bits then channel bits
    typedef logic [`FB_SUBPANEL_BITS + `FB_CHANNEL_BITS - 1:0] laneIdx_t;

    typedef logic [`FB_DATA_BITS - 1:0] pixelByte_t;

    // lane k sits in byte k
    typedef logic [`FB_LANES * `FB_DATA_BITS - 1:0] laneWord_t;

    // one data pin per lane
    typedef logic [`FB_LANES - 1:0] panelBits_t;

    typedef logic [`FB_ROW_BITS - 1:0] rowAddr_t;

    // msb selects the control register, the rest is a pixel address
    typedef logic [$bits(pixelAddr_t):0] wbAddr_t;

    typedef enum logic [2:0] {Idle, Prime, Shift, Latch, Display} scanState_t;

endpackage

/* hdl/fbMemLane.sv */
// one framebuffer lane: simple dual-port block RAM
// write port from the host side, registered read port for the scanner

`include "fb_macros.svh"

module fbMemLane (
    input  logic              ClockA,
    input  logic              writeEn,
    input  fbPkg::bodyAddr_t  writeAddr,
    input  fbPkg::pixelByte_t writeData,
    input  logic              readEn,
    input  fbPkg::bodyAddr_t  readAddr,
    output fbPkg::pixelByte_t readData
);
    import fbPkg::*;

    // one byte per row and column of a subpanel
    localparam int Depth = 1 << (`FB_ROW_BITS + `FB_COL_BITS);

    pixelByte_t mem [Depth];

    // write port
    always_ff @(posedge ClockA) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read port, output register holds while readEn is low
    always_ff @(posedge ClockA) begin
        if (readEn) begin
            readData <= mem[readAddr];
        end
    end

endmodule

/* hdl/fbMultiMem.sv */
// banked framebuffer, one lane per subpanel and colour channel
// host writes one byte at a time, the scanner reads all lanes in one access

`include "fb_macros.svh"

module fbMultiMem (
    input  logic              ClockA,
    input  logic              reset,
    input  logic              memWe,
    input  fbPkg::pixelAddr_t memAddr,
    input  fbPkg::pixelByte_t memData,
    input  logic              rdEn,
    input  fbPkg::bodyAddr_t  rdAddr,
    output fbPkg::laneWord_t  rdData
);
    import fbPkg::*;

    localparam int AddrBits = $bits(pixelAddr_t);
    localparam int BodyBits = $bits(bodyAddr_t);

    laneIdx_t               writeLane;
    logic [`FB_LANES-1:0]   laneWeNext;
    logic [`FB_LANES-1:0]   laneWeQ;
    bodyAddr_t              bodyAddrQ;
    pixelByte_t             dataQ;

    // lane = subpanel bits on top, channel bits at the bottom
    assign writeLane = {memAddr[AddrBits-1 -: `FB_SUBPANEL_BITS],
                        memAddr[`FB_CHANNEL_BITS-1:0]};

    // one-hot decode of the target lane
    always_comb begin
        laneWeNext = '0;
        if (memWe) begin
            laneWeNext[writeLane] = 1'b1;
        end
    end

    always_ff @(posedge ClockA) begin
        if (reset) begin
            laneWeQ <= '0;
        end else begin
            laneWeQ <= laneWeNext;
        end
    end

    // body address is row and column, shared by every lane
    always_ff @(posedge ClockA) begin
        bodyAddrQ <= memAddr[AddrBits-`FB_SUBPANEL_BITS-1 -: BodyBits];
        dataQ     <= memData;
    end

    for (genvar k = 0; k < `FB_LANES; k++) begin : gLane
        fbMemLane u_fbMemLane (
            .ClockA   (ClockA),
            .writeEn  (laneWeQ[k]),
            .writeAddr(bodyAddrQ),
            .writeData(dataQ),
            .readEn   (rdEn),
            .readAddr (rdAddr),
            // byte k of the wide word
            .readData (rdData[k*`FB_DATA_BITS +: `FB_DATA_BITS])
        );
    end

    // a single host write never lands in two lanes
    laneWeOneHot: assert property (@(posedge ClockA) disable iff (reset)
        $onehot0(laneWeQ));

endmodule

/* hdl/wbFbSlave.sv */
// Wishbone classic slave for the framebuffer
// forwards pixel writes to memory and holds the scan-enable register

module wbFbSlave (
    input  logic              ClockA,
    input  logic              reset,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  fbPkg::wbAddr_t    wbAdr,
    input  fbPkg::pixelByte_t wbDatW,
    output fbPkg::pixelByte_t wbDatR,
    output logic              wbAck,
    output logic              wbErr,
    output logic              memWe,
    output fbPkg::pixelAddr_t memAddr,
    output fbPkg::pixelByte_t memData,
    output logic              scanEnable
);
    import fbPkg::*;

    logic request;
    logic ctrlSel;
    logic pixelWrite;

    // skip the cycle right after a termination, strobe is still held there
    assign request = wbCyc && wbStb && !wbAck && !wbErr;

    // top address bit picks the control register
    assign ctrlSel    = wbAdr[$bits(wbAddr_t)-1];
    assign pixelWrite = request && !ctrlSel && wbWe;

    always_ff @(posedge ClockA) begin
        if (reset) begin
            wbAck      <= 1'b0;
            wbErr      <= 1'b0;
            memWe      <= 1'b0;
            scanEnable <= 1'b0;
        end else begin
            // pixel reads are not supported and end with an error
            wbAck <= request && (ctrlSel || wbWe);
            wbErr <= request && !ctrlSel && !wbWe;
            // memory write pulse lines up with the ack
            memWe <= pixelWrite;
            if (request && ctrlSel && wbWe) begin
                scanEnable <= wbDatW[0];
            end
        end
    end

    // payload registers
    always_ff @(posedge ClockA) begin
        if (pixelWrite) begin
            memAddr <= wbAdr[$bits(pixelAddr_t)-1:0];
            memData <= wbDatW;
        end
        // control readback, enable in bit 0
        if (request && ctrlSel && !wbWe) begin
            wbDatR <= pixelByte_t'(scanEnable);
        end
    end

    ackErrExclusive: assert property (@(posedge ClockA) disable iff (reset)
        !(wbAck && wbErr));

endmodule

/* hdl/panelScanner.sv */
// scan engine for the RGBW panel
// walks rows and bitplanes, shifts one column per cycle, latches, then
// displays for a time that doubles with each bitplane

`include "fb_macros.svh"

module panelScanner (
    input  logic              ClockA,
    input  logic              reset,
    input  logic              scanEnable,
    input  fbPkg::laneWord_t  rdData,
    output logic              rdEn,
    output fbPkg::bodyAddr_t  rdAddr,
    output fbPkg::panelBits_t panelData,
    output logic              panelShift,
    output logic              panelLatch,
    output fbPkg::rowAddr_t   panelRow,
    output logic              panelBlank
);
    import fbPkg::*;

    localparam int ColBits   = `FB_COL_BITS;
    localparam int PlaneBits = $clog2(`FB_DATA_BITS);
    // longest display time is the top plane
    localparam int DispBits  = $clog2((`FB_OE_UNIT << (`FB_DATA_BITS - 1)) + 1);

    localparam logic [ColBits-1:0]   LastCol   = '1;
    localparam logic [PlaneBits-1:0] LastPlane = PlaneBits'(`FB_DATA_BITS - 1);

    scanState_t           state;
    logic [ColBits-1:0]   col;
    logic [ColBits-1:0]   colNext;
    logic [ColBits-1:0]   readCol;
    logic [PlaneBits-1:0] plane;
    rowAddr_t             row;
    logic [DispBits-1:0]  dispCnt;

    assign colNext = col + 1'b1;

    always_ff @(posedge ClockA) begin
        if (reset) begin
            state   <= Idle;
            col     <= '0;
            plane   <= '0;
            row     <= '0;
            dispCnt <= '0;
        end else if (!scanEnable) begin
            // stop at once, restart from the top of the frame
            state <= Idle;
            col   <= '0;
            plane <= '0;
            row   <= '0;
        end else begin
            case (state)
                Idle: begin
                    state <= Prime;
                end
                Prime: begin
                    state <= Shift;
                    col   <= '0;
                end
                Shift: begin
                    if (col == LastCol) begin
                        state <= Latch;
                    end else begin
                        col <= colNext;
                    end
                end
                Latch: begin
                    state   <= Display;
                    // counts down to zero, so load one less
                    dispCnt <= (DispBits'(`FB_OE_UNIT) << plane) - 1'b1;
                end
                Display: begin
                    if (dispCnt == '0) begin
                        state <= Prime;
                        // planes inside a row, row counter wraps on its own
                        if (plane == LastPlane) begin
                            plane <= '0;
                            row   <= row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        dispCnt <= dispCnt - 1'b1;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // column 0 is fetched in Prime, then always one column ahead during Shift
    assign readCol = (state == Prime) ? '0 : colNext;
    assign rdEn    = (state == Prime) || (state == Shift && col != LastCol);
    assign rdAddr  = {row, readCol};

    // bit p of every lane byte for the current column
    always_comb begin
        for (int k = 0; k < `FB_LANES; k++) begin
            panelData[k] = rdData[k*`FB_DATA_BITS + plane];
        end
    end

    assign panelShift = (state == Shift);
    assign panelLatch = (state == Latch);
    assign panelRow   = row;
    assign panelBlank = (state != Display);

    shiftLatchExclusive: assert property (@(posedge ClockA) disable iff (reset)
        !(panelShift && panelLatch));

    // never light the row while new column data is moving in
    blankWhileShift: assert property (@(posedge ClockA) disable iff (reset)
        panelShift |-> panelBlank);

endmodule

/* hdl/ledPanelTop.sv */
// top level of the RGBW panel controller
// Wishbone slave feeds the banked framebuffer, the scanner drives the panel

module ledPanelTop (
    input  logic              ClockA,
    input  logic              reset,
    // Wishbone classic slave
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  fbPkg::wbAddr_t    wbAdr,
    input  fbPkg::pixelByte_t wbDatW,
    output fbPkg::pixelByte_t wbDatR,
    output logic              wbAck,
    output logic              wbErr,
    // panel pins
    output fbPkg::panelBits_t panelData,
    output logic              panelShift,
    output logic              panelLatch,
    output fbPkg::rowAddr_t   panelRow,
    output logic              panelBlank
);
    import fbPkg::*;

    // host write path
    logic       memWe;
    pixelAddr_t memAddr;
    pixelByte_t memData;
    logic       scanEnable;

    // scanner read path
    logic       rdEn;
    bodyAddr_t  rdAddr;
    laneWord_t  rdData;

    wbFbSlave u_wbFbSlave (
        .ClockA    (ClockA),
        .reset     (reset),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .wbErr     (wbErr),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memData   (memData),
        .scanEnable(scanEnable)
    );

    fbMultiMem u_fbMultiMem (
        .ClockA (ClockA),
        .reset  (reset),
        .memWe  (memWe),
        .memAddr(memAddr),
        .memData(memData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    panelScanner u_panelScanner (
        .ClockA    (ClockA),
        .reset     (reset),
        .scanEnable(scanEnable),
        .rdData    (rdData),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .panelData (panelData),
        .panelShift(panelShift),
        .panelLatch(panelLatch),
        .panelRow  (panelRow),
        .panelBlank(panelBlank)
    );

endmodule

/* sim/panelChecker.sv */
// bus and panel monitor: snoops Wishbone to keep a frame model and the enable,
// predicts every panel pin cycle by cycle and counts mismatches

`include "fb_macros.svh"

module panelChecker (
    input  logic              ClockA,
    input  logic              reset,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  fbPkg::wbAddr_t    wbAdr,
    input  fbPkg::pixelByte_t wbDatW,
    input  fbPkg::pixelByte_t wbDatR,
    input  logic              wbAck,
    input  logic              wbErr,
    input  fbPkg::panelBits_t panelData,
    input  logic              panelShift,
    input  logic              panelLatch,
    input  fbPkg::rowAddr_t   panelRow,
    input  logic              panelBlank,
    output int                errorCount,
    output int                checkCount
);
    timeunit 1ns;
    timeprecision 100ps;
    import fbPkg::*;

    localparam int PixBits = $bits(pixelAddr_t);
    localparam int Cols    = 1 << `FB_COL_BITS;
    localparam int Rows    = 1 << `FB_ROW_BITS;
    localparam int Planes  = `FB_DATA_BITS;

    pixelByte_t frameModel [1 << PixBits];
    logic       modelEn;
    // request seen at the last edge, terminated at this one
    logic       pendValid;
    // a termination is expected in the cycle that ends at this edge
    logic       termDue;
    logic       pendWe;
    wbAddr_t    pendAdr;
    pixelByte_t pendDat;
    scanState_t phase;
    int         row;
    int         plane;
    int         col;
    int         dispLeft;
    int         shiftRun;

    task automatic compareValue(input string name, input logic [63:0] expected,
                                input logic [63:0] observed);
        checkCount++;
        if (observed !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s expected %0h, observed %0h",
                     $time, name, expected, observed);
        end
    endtask

    // bit p of each lane byte, lane k = subpanel bits over channel bits
    function automatic panelBits_t expectedColumnBits(input int r, input int c, input int p);
        panelBits_t bits;
        int         addr;
        for (int k = 0; k < `FB_LANES; k++) begin
            addr = ((k >> `FB_CHANNEL_BITS) << (PixBits - `FB_SUBPANEL_BITS))
                 | (r << (`FB_COL_BITS + `FB_CHANNEL_BITS))
                 | (c << `FB_CHANNEL_BITS)
                 | (k & ((1 << `FB_CHANNEL_BITS) - 1));
            bits[k] = frameModel[addr][p];
        end
        return bits;
    endfunction

    task automatic checkBus();
        logic ctrl;
        ctrl = pendAdr[PixBits];
        // pixel reads end in an error, everything else in an ack
        compareValue("wbAck", pendValid && (ctrl || pendWe), wbAck);
        compareValue("wbErr", pendValid && !ctrl && !pendWe, wbErr);
        if (pendValid && ctrl && pendWe) begin
            modelEn = pendDat[0];
        end else if (pendValid && ctrl) begin
            compareValue("wbDatR", modelEn, wbDatR);
        end else if (pendValid && pendWe) begin
            frameModel[pendAdr[PixBits-1:0]] = pendDat;
        end
        pendValid = 1'b0;
    endtask

    task automatic checkPanel();
        compareValue("panelShift", phase == Shift, panelShift);
        compareValue("panelLatch", phase == Latch, panelLatch);
        compareValue("panelBlank", phase != Display, panelBlank);
        if (phase == Prime) begin
            shiftRun = 0;
        end
        if (phase == Shift) begin
            compareValue("panelData", expectedColumnBits(row, col, plane), panelData);
        end
        if (panelShift) begin
            shiftRun++;
        end
        if (panelLatch) begin
            compareValue("panelShift count before panelLatch", Cols, shiftRun);
            compareValue("panelRow", row, panelRow);
        end
    endtask

    // expected phase for the next cycle
    task automatic advanceScan();
        if (!modelEn) begin
            phase = Idle;
            row   = 0;
            plane = 0;
            col   = 0;
        end else begin
            case (phase)
                Idle: phase = Prime;
                Prime: begin
                    phase = Shift;
                    col   = 0;
                end
                Shift: begin
                    if (col == Cols - 1) begin
                        phase = Latch;
                    end else begin
                        col++;
                    end
                end
                Latch: begin
                    phase    = Display;
                    dispLeft = `FB_OE_UNIT << plane;
                end
                default: begin
                    dispLeft--;
                    if (dispLeft == 0) begin
                        phase = Prime;
                        // planes inside a row, rows wrap after the last one
                        if (plane == Planes - 1) begin
                            plane = 0;
                            row   = (row + 1) % Rows;
                        end else begin
                            plane++;
                        end
                    end
                end
            endcase
        end
    endtask

    always @(posedge ClockA) begin
        if (reset) begin
            modelEn    = 1'b0;
            pendValid  = 1'b0;
            phase      = Idle;
            row        = 0;
            plane      = 0;
            col        = 0;
            shiftRun   = 0;
            errorCount = 0;
            checkCount = 0;
        end else begin
            termDue = pendValid;
            checkBus();
            checkPanel();
            advanceScan();
            // a held strobe right after a termination is not a new request
            if (wbCyc && wbStb && !termDue) begin
                pendValid = 1'b1;
                pendWe    = wbWe;
                pendAdr   = wbAdr;
                pendDat   = wbDatW;
            end
        end
    end

endmodule

/* sim/tbTop.sv */
// testbench top: clock, reset and a Wishbone host for the panel controller
// loads random frames, runs the scanner and prints the final result

module tbTop;
    timeunit 1ns;
    timeprecision 100ps;
    import fbPkg::*;

    localparam int Seed         = 63341;
    localparam int BusTimeout   = 16;
    // longest gap between latches is a row of shifts plus the top plane
    localparam int LatchTimeout = 1000;
    localparam int Pixels       = 1 << $bits(pixelAddr_t);
    localparam wbAddr_t CtrlAddr = wbAddr_t'(1) << $bits(pixelAddr_t);

    logic       ClockA;
    logic       reset;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    wbAddr_t    wbAdr;
    pixelByte_t wbDatW;
    pixelByte_t wbDatR;
    logic       wbAck;
    logic       wbErr;
    panelBits_t panelData;
    logic       panelShift;
    logic       panelLatch;
    rowAddr_t   panelRow;
    logic       panelBlank;
    int         checkerErrors;
    int         checkCount;
    int         timeoutCount;

    initial ClockA = 1'b0;
    always #4 ClockA = ~ClockA;

    ledPanelTop u_ledPanelTop (
        .ClockA(ClockA), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck), .wbErr(wbErr),
        .panelData(panelData), .panelShift(panelShift), .panelLatch(panelLatch),
        .panelRow(panelRow), .panelBlank(panelBlank)
    );

    panelChecker u_panelChecker (
        .ClockA(ClockA), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck), .wbErr(wbErr),
        .panelData(panelData), .panelShift(panelShift), .panelLatch(panelLatch),
        .panelRow(panelRow), .panelBlank(panelBlank),
        .errorCount(checkerErrors), .checkCount(checkCount)
    );

    task automatic finishRun();
        int errors;
        errors = checkerErrors + timeoutCount;
        $display("%0d checks, %0d mismatches, %0d timeouts, %0d errors",
                 checkCount, checkerErrors, timeoutCount, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // one classic cycle, then an idle cycle before the next one
    task automatic busAccess(input wbAddr_t adr, input logic we, input pixelByte_t dat);
        int waited;
        waited = 0;
        // nothing more goes on the bus once an access has timed out
        if (timeoutCount != 0) begin
            return;
        end
        @(posedge ClockA);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatW <= dat;
        do begin
            @(posedge ClockA);
            waited++;
        end while (!(wbAck || wbErr) && waited < BusTimeout);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        if (!(wbAck || wbErr)) begin
            $display("timeout: Wishbone access to %h was never terminated", adr);
            timeoutCount++;
        end
    endtask

    task automatic waitLatches(input int count);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        if (timeoutCount != 0) begin
            return;
        end
        while (seen < count && idle < LatchTimeout) begin
            @(posedge ClockA);
            if (panelLatch) begin
                seen++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (seen < count) begin
            $display("timeout: only %0d of %0d row latches seen", seen, count);
            timeoutCount++;
        end
    endtask

    // every pixel address gets a fresh random byte
    task automatic writeFrame();
        for (int a = 0; a < Pixels; a++) begin
            busAccess(wbAddr_t'(a), 1'b1, pixelByte_t'($urandom));
        end
    endtask

    initial begin
        reset        = 1'b1;
        wbCyc        = 1'b0;
        wbStb        = 1'b0;
        wbWe         = 1'b0;
        wbAdr        = '0;
        wbDatW       = '0;
        timeoutCount = 0;
        void'($urandom(Seed));
        repeat (5) @(posedge ClockA);
        reset <= 1'b0;
        // enable reads back as zero after reset
        busAccess(CtrlAddr, 1'b0, '0);
        // pixel memory is write only
        repeat (4) busAccess(wbAddr_t'($urandom_range(Pixels - 1)), 1'b0, '0);
        writeFrame();
        busAccess(CtrlAddr, 1'b1, 8'h01);
        busAccess(CtrlAddr, 1'b0, '0);
        // a full frame is 64 latches, two more show the wrap
        waitLatches(66);
        // stop, load a new frame, restart from the top
        busAccess(CtrlAddr, 1'b1, 8'h00);
        busAccess(CtrlAddr, 1'b0, '0);
        writeFrame();
        busAccess(CtrlAddr, 1'b1, 8'h01);
        waitLatches(16);
        busAccess(CtrlAddr, 1'b1, 8'h00);
        repeat (4) @(posedge ClockA);
        finishRun();
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/fbPkg.sv
hdl/fbMemLane.sv
hdl/fbMultiMem.sv
hdl/wbFbSlave.sv
hdl/panelScanner.sv
hdl/ledPanelTop.sv
sim/panelChecker.sv
sim/tbTop.sv

/* Makefile */
# Verilator build and run of the panel controller testbench

TOP = tbTop

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f filelist.f -o simTb
	@out="$$(./obj_dir/simTb)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
